//--- Makefile
VERILATOR ?= verilator
TOP       ?= fpAddTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timescale 1ns/100ps --assert
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- source/fpAddRound.sv
// Significand add, normalize and round to nearest even
module fpAddRound
    import fpPkg::*;
(
    input  logic              signA,
    input  logic              signB,
    input  logic              swapped,
    input  logic              nanA,
    input  logic              nanB,
    input  logic              infA,
    input  logic              infB,
    input  logic              zeroA,
    input  logic              zeroB,
    input  logic              bypass,
    input  logic [31:0]       opWordA,
    input  logic [31:0]       opWordB,
    input  logic [expW-1:0]   expIn,
    input  logic [alignW-1:0] alignA,
    input  logic [alignW-1:0] alignB,
    output logic [31:0]       result,
    output logic              invalid,
    output logic              overflow,
    output logic              underflow,
    output logic              inexact
);
    logic                   effSub;
    logic                   signBig;
    logic [alignW:0]        sum;
    logic [4:0]             lz;
    logic [alignW-1:0]      norm;
    logic signed [expW+1:0] expNorm;
    logic signed [expW+1:0] expFinal;
    logic                   guardBit;
    logic                   roundBit;
    logic                   stickyBit;
    logic                   roundUp;
    logic [sigW:0]          rounded;
    logic [fracW-1:0]       fracOut;

    assign effSub  = signA ^ signB;
    assign signBig = swapped ? signB : signA;

    // First operand is never the smaller, so the difference stays positive
    assign sum = effSub ? ({1'b0, alignA} - {1'b0, alignB})
                        : ({1'b0, alignA} + {1'b0, alignB});

    // Leading zeros below the carry position
    always_comb
    begin
        lz = '0;
        for (int i = 0; i < alignW; i++)
        begin
            if (sum[i])
                lz = 5'(alignW - 1 - i);
        end
    end

    always_comb
    begin
        if (sum[alignW])
        begin
            // Carry out, one step right and keep the lost bit in sticky
            norm    = {sum[alignW:2], sum[1] | sum[0]};
            expNorm = $signed({2'b00, expIn}) + 10'sd1;
        end
        else
        begin
            norm    = sum[alignW-1:0] << lz;
            expNorm = $signed({2'b00, expIn}) - $signed({5'b00000, lz});
        end
    end

    assign guardBit  = norm[2];
    assign roundBit  = norm[1];
    assign stickyBit = norm[0];

    // Ties go to the even significand
    assign roundUp  = guardBit & (roundBit | stickyBit | norm[3]);
    assign rounded  = {1'b0, norm[alignW-1:3]} + (sigW + 1)'(roundUp);
    assign expFinal = rounded[sigW] ? expNorm + 10'sd1 : expNorm;
    assign fracOut  = rounded[sigW] ? rounded[fracW:1] : rounded[fracW-1:0];

    always_comb
    begin
        invalid   = 1'b0;
        overflow  = 1'b0;
        underflow = 1'b0;
        inexact   = 1'b0;
        if (bypass)
        begin
            if (nanA | nanB | (infA & infB & effSub))
            begin
                result  = quietNaN;
                invalid = 1'b1;
            end
            else if (infA)
                result = opWordA;
            else if (infB)
                result = opWordB;
            else if (zeroA & zeroB)
                result = {signA & signB, 31'b0};
            else if (zeroA)
                result = opWordB;
            else
                result = opWordA;
        end
        else if (sum == '0)
            result = '0;
        else if (expFinal >= $signed({2'b00, expMax}))
        begin
            result   = {signBig, expMax, {fracW{1'b0}}};
            overflow = 1'b1;
            inexact  = 1'b1;
        end
        else if (expFinal <= 10'sd0)
        begin
            // No gradual underflow, flush to signed zero
            result    = {signBig, 31'b0};
            underflow = 1'b1;
            inexact   = 1'b1;
        end
        else
        begin
            result  = {signBig, expFinal[expW-1:0], fracOut};
            inexact = guardBit | roundBit | stickyBit;
        end
    end

endmodule

//--- source/fpAddWb.sv
// Floating-point adder Wishbone slave
module fpAddWb
    import fpPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [31:0] wbAdr,
    input  logic [31:0] wbDatI,
    // Byte selects ignored, every access is a full word
    input  logic [3:0]  wbSel,
    output logic [31:0] wbDatO,
    output logic        wbAck
);
    logic [31:0]       opA;
    logic [31:0]       opB;
    logic [31:0]       ctrl;
    logic [31:0]       resultReg;
    logic [31:0]       statusReg;
    logic [31:0]       opBEff;
    logic [31:0]       sumWord;
    logic [31:0]       statusNext;
    logic [31:0]       readMux;
    logic [2:0]        regSel;
    logic              request;
    logic              signA, signB, nanA, nanB, infA, infB, zeroA, zeroB;
    logic [expW-1:0]   expA, expB, expAligned;
    logic [sigW-1:0]   sigA, sigB;
    logic [alignW-1:0] alignA, alignB;
    logic              swapped, bypass;
    logic              invalid, overflow, underflow, inexact;

    assign request = wbCyc & wbStb & ~wbAck;
    assign regSel  = wbAdr[4:2];

    // Subtraction is addition with B negated
    assign opBEff = {opB[31] ^ ctrl[0], opB[30:0]};

    fpUnpack uA (.opWord(opA), .sign(signA), .expEff(expA), .sig(sigA),
                 .isNaN(nanA), .isInf(infA), .isZero(zeroA));
    fpUnpack uB (.opWord(opBEff), .sign(signB), .expEff(expB), .sig(sigB),
                 .isNaN(nanB), .isInf(infB), .isZero(zeroB));

    fpAlign uAlign (.expA(expA), .expB(expB), .sigA(sigA), .sigB(sigB),
                    .nanA(nanA), .nanB(nanB), .infA(infA), .infB(infB),
                    .zeroA(zeroA), .zeroB(zeroB), .expOut(expAligned),
                    .alignA(alignA), .alignB(alignB), .swapped(swapped), .bypass(bypass));

    fpAddRound uRound (.signA(signA), .signB(signB), .swapped(swapped),
                       .nanA(nanA), .nanB(nanB), .infA(infA), .infB(infB),
                       .zeroA(zeroA), .zeroB(zeroB), .bypass(bypass),
                       .opWordA(opA), .opWordB(opBEff), .expIn(expAligned),
                       .alignA(alignA), .alignB(alignB), .result(sumWord),
                       .invalid(invalid), .overflow(overflow),
                       .underflow(underflow), .inexact(inexact));

    always_comb
    begin
        statusNext                  = '0;
        statusNext[statusInvalid]   = invalid;
        statusNext[statusOverflow]  = overflow;
        statusNext[statusUnderflow] = underflow;
        statusNext[statusInexact]   = inexact;
    end

    always_comb
    begin
        case (regSel)
            addrOpA:    readMux = opA;
            addrOpB:    readMux = opB;
            addrCtrl:   readMux = ctrl;
            addrResult: readMux = resultReg;
            addrStatus: readMux = statusReg;
            default:    readMux = '0;
        endcase
    end

    // Bus side, one ack per request and write at the ack edge
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wbAck  <= 1'b0;
            wbDatO <= '0;
            opA    <= '0;
            opB    <= '0;
            ctrl   <= '0;
        end
        else
        begin
            wbAck <= request;
            if (request)
                wbDatO <= readMux;
            if (request && wbWe)
            begin
                case (regSel)
                    addrOpA:  opA  <= wbDatI;
                    addrOpB:  opB  <= wbDatI;
                    addrCtrl: ctrl <= wbDatI;
                    default:  ;
                endcase
            end
        end
    end

    // Result and status follow the datapath every cycle
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            resultReg <= '0;
            statusReg <= '0;
        end
        else
        begin
            resultReg <= sumWord;
            statusReg <= statusNext;
        end
    end

endmodule

//--- source/fpAlign.sv
// Exponent compare and significand alignment
module fpAlign
    import fpPkg::*;
(
    input  logic [expW-1:0]   expA,
    input  logic [expW-1:0]   expB,
    input  logic [sigW-1:0]   sigA,
    input  logic [sigW-1:0]   sigB,
    input  logic              nanA,
    input  logic              nanB,
    input  logic              infA,
    input  logic              infB,
    input  logic              zeroA,
    input  logic              zeroB,
    output logic [expW-1:0]   expOut,
    output logic [alignW-1:0] alignA,
    output logic [alignW-1:0] alignB,
    output logic              swapped,
    output logic              bypass
);
    logic                   aFirst;
    logic [expW-1:0]        expBig;
    logic [expW-1:0]        expSmall;
    logic [sigW-1:0]        sigBig;
    logic [sigW-1:0]        sigSmall;
    logic [expW-1:0]        expDiff;
    logic [sigW+alignW:0]   shiftWide;

    // Special operands skip the arithmetic path
    assign bypass = nanA | nanB | infA | infB | zeroA | zeroB;

    // Larger magnitude goes first, ties on exponent broken by significand
    assign aFirst  = (expA > expB) || ((expA == expB) && (sigA >= sigB));
    assign swapped = ~aFirst;

    always_comb
    begin
        if (aFirst)
        begin
            expBig   = expA;
            expSmall = expB;
            sigBig   = sigA;
            sigSmall = sigB;
        end
        else
        begin
            expBig   = expB;
            expSmall = expA;
            sigBig   = sigB;
            sigSmall = sigA;
        end
    end

    assign expDiff = expBig - expSmall;
    assign expOut  = expBig;

    // Wide frame keeps every shifted bit so the sticky OR is exact
    assign shiftWide = {sigSmall, {(alignW + 1){1'b0}}} >> expDiff;

    assign alignA = {sigBig, {(alignW - sigW){1'b0}}};

    always_comb
    begin
        if (expDiff > expW'(alignW - 1))
        begin
            // Whole operand lands below the round position
            alignB = {{(alignW - 1){1'b0}}, |sigSmall};
        end
        else
        begin
            alignB = {shiftWide[sigW+alignW:alignW-1], |shiftWide[alignW-2:0]};
        end
    end

endmodule

//--- source/fpPkg.sv
// Floating-point adder definitions
package fpPkg;

    // Single-precision field widths
    localparam int expW   = 8;
    localparam int fracW  = 23;
    localparam int sigW   = 24;

    // Significand followed by guard, round and sticky
    localparam int alignW = 27;

    localparam logic [expW-1:0] expMax   = 8'd255;
    localparam logic [31:0]     quietNaN = 32'h7FC0_0000;

    // Register word offsets, taken from byte address bits 4 to 2
    localparam logic [2:0] addrOpA    = 3'd0;
    localparam logic [2:0] addrOpB    = 3'd1;
    localparam logic [2:0] addrCtrl   = 3'd2;
    localparam logic [2:0] addrResult = 3'd3;
    localparam logic [2:0] addrStatus = 3'd4;

    // Status word bit positions
    localparam int statusInvalid   = 0;
    localparam int statusOverflow  = 1;
    localparam int statusUnderflow = 2;
    localparam int statusInexact   = 3;

    typedef struct packed
    {
        logic             sign;
        logic [expW-1:0]  exp;
        logic [fracW-1:0] frac;
    } fpFields_s;

    // Same operand word, seen raw or as IEEE-754 fields
    typedef union packed
    {
        logic [31:0] raw;
        fpFields_s   f;
    } fpWord_u;

endpackage

//--- source/fpUnpack.sv
// Operand unpack and classify
module fpUnpack
    import fpPkg::*;
(
    input  logic [31:0]     opWord,
    output logic            sign,
    output logic [expW-1:0] expEff,
    output logic [sigW-1:0] sig,
    output logic            isNaN,
    output logic            isInf,
    output logic            isZero
);
    fpWord_u w;
    logic    expAllOnes;
    logic    expAllZero;
    logic    fracZero;
    logic    isSub;

    assign w.raw = opWord;

    assign expAllOnes = (w.f.exp == expMax);
    assign expAllZero = (w.f.exp == '0);
    assign fracZero   = (w.f.frac == '0);

    // Classification
    assign isNaN  = expAllOnes & ~fracZero;
    assign isInf  = expAllOnes & fracZero;
    assign isZero = expAllZero & fracZero;
    assign isSub  = expAllZero & ~fracZero;

    assign sign = w.f.sign;

    // Subnormals sit at exponent 1 with no hidden bit
    assign expEff = isSub ? expW'(1) : w.f.exp;
    assign sig    = {~expAllZero, w.f.frac};

endmodule

//--- src.f
source/fpPkg.sv
source/fpUnpack.sv
source/fpAlign.sv
source/fpAddRound.sv
source/fpAddWb.sv
tb/fpAddWb_checker.sv
tb/fpAddTb.sv

//--- tb/fpAddTb.sv
// Floating-point adder testbench
module fpAddTb
    import fpPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Directed operations plus add and subtract for every random pair, five words each
    localparam int directedOps = 30;
    localparam int transfers   = directedOps * 5 + 2 * 200 * 5 + 10;
    localparam int timeLimit   = transfers * 3 * 20 * 2;

    localparam logic [3:0] flagInv = 4'b1 << statusInvalid;
    localparam logic [3:0] flagInx = 4'b1 << statusInexact;
    localparam logic [3:0] flagOvf = (4'b1 << statusOverflow) | flagInx;
    localparam logic [3:0] flagUnf = (4'b1 << statusUnderflow) | flagInx;

    logic        clk;
    logic        arstN;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [31:0] wbAdr;
    logic [31:0] wbDatI;
    logic [3:0]  wbSel;
    logic [31:0] wbDatO;
    logic        wbAck;
    int          errCount;
    int          checkCount;
    int          seed;

    fpAddWb i_dut (.clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
                   .wbAdr(wbAdr), .wbDatI(wbDatI), .wbSel(wbSel), .wbDatO(wbDatO),
                   .wbAck(wbAck));

    always #10 clk = ~clk;

    // Exact reference, big operand scaled up so small shifts lose nothing
    function automatic logic [31:0] fpAddModel(input logic [31:0] a, input logic [31:0] b,
                                               input logic sub, output logic [3:0] flags);
        fpWord_u     x;
        fpWord_u     y;
        fpWord_u     bigW;
        fpWord_u     smallW;
        logic        nanX;
        logic        nanY;
        logic        infX;
        logic        infY;
        int          expBig;
        int          expSmall;
        int          d;
        int          p;
        int          e;
        int          sh;
        logic [63:0] mBig;
        logic [63:0] mSmall;
        logic [63:0] m;
        logic [63:0] keep;
        logic [63:0] rem;
        logic [63:0] half;
        x.raw = a;
        y.raw = b;
        y.f.sign = b[31] ^ sub;
        flags = '0;
        nanX = (x.f.exp == 8'hFF) && (x.f.frac != 0);
        nanY = (y.f.exp == 8'hFF) && (y.f.frac != 0);
        infX = (x.f.exp == 8'hFF) && (x.f.frac == 0);
        infY = (y.f.exp == 8'hFF) && (y.f.frac == 0);
        if (nanX || nanY || (infX && infY && (x.f.sign != y.f.sign)))
        begin
            flags = flagInv;
            return quietNaN;
        end
        if (infX)
            return x.raw;
        if (infY)
            return y.raw;
        if ((x.raw[30:0] == 0) && (y.raw[30:0] == 0))
            return {x.f.sign & y.f.sign, 31'b0};
        if (x.raw[30:0] == 0)
            return y.raw;
        if (y.raw[30:0] == 0)
            return x.raw;
        // Magnitude order follows the raw bits below the sign
        bigW   = (x.raw[30:0] >= y.raw[30:0]) ? x : y;
        smallW = (x.raw[30:0] >= y.raw[30:0]) ? y : x;
        expBig   = (bigW.f.exp == 0) ? 1 : int'(bigW.f.exp);
        expSmall = (smallW.f.exp == 0) ? 1 : int'(smallW.f.exp);
        mBig   = {40'b0, bigW.f.exp != 0, bigW.f.frac} << 36;
        mSmall = {40'b0, smallW.f.exp != 0, smallW.f.frac} << 36;
        d = expBig - expSmall;
        if (d > 60)
            mSmall = (mSmall != 0) ? 64'd1 : 64'd0;
        else
        begin
            keep = mSmall >> d;
            if ((keep << d) != mSmall)
                keep = keep | 64'd1;
            mSmall = keep;
        end
        m = (bigW.f.sign != smallW.f.sign) ? mBig - mSmall : mBig + mSmall;
        if (m == 0)
            return 32'h0;
        p = 63;
        while (!m[p])
            p--;
        e  = expBig + p - 59;
        sh = p - 23;
        keep = m >> sh;
        rem  = m & ((64'd1 << sh) - 64'd1);
        half = 64'd1 << (sh - 1);
        if ((rem > half) || ((rem == half) && keep[0]))
            keep = keep + 64'd1;
        if (keep[24])
        begin
            keep = keep >> 1;
            e++;
        end
        if (e >= 255)
        begin
            flags = flagOvf;
            return {bigW.f.sign, 8'hFF, 23'b0};
        end
        if (e <= 0)
        begin
            flags = flagUnf;
            return {bigW.f.sign, 31'b0};
        end
        flags = (rem != 0) ? flagInx : 4'b0;
        return {bigW.f.sign, e[7:0], keep[22:0]};
    endfunction

    // Called on a falling edge, so a new request follows the previous ack at once
    task automatic busTransfer(input logic [2:0] regOff, input logic we,
                               input logic [31:0] dataIn, output logic [31:0] dataOut);
        int waitCycles;
        waitCycles = 0;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = {27'b0, regOff, 2'b00};
        wbDatI = dataIn;
        @(negedge clk);
        while (!wbAck && (waitCycles < 10))
        begin
            waitCycles++;
            @(negedge clk);
        end
        if (!wbAck)
        begin
            $display("Bus transfer to register %0d was never acknowledged", regOff);
            errCount++;
        end
        dataOut = wbDatO;
        wbCyc   = 1'b0;
        wbStb   = 1'b0;
        wbWe    = 1'b0;
    endtask

    task automatic wbWrite(input logic [2:0] regOff, input logic [31:0] data);
        logic [31:0] unused;
        busTransfer(regOff, 1'b1, data, unused);
    endtask

    task automatic wbRead(input logic [2:0] regOff, output logic [31:0] data);
        busTransfer(regOff, 1'b0, 32'h0, data);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic runOp(input string name, input logic [31:0] a, input logic [31:0] b,
                         input logic sub, input logic [31:0] expRes, input logic [3:0] expStat);
        logic [31:0] rd;
        wbWrite(addrOpA, a);
        wbWrite(addrOpB, b);
        wbWrite(addrCtrl, {31'b0, sub});
        wbRead(addrResult, rd);
        checkValue({name, " result"}, expRes, rd);
        wbRead(addrStatus, rd);
        checkValue({name, " status"}, {28'b0, expStat}, rd);
    endtask

    task automatic resetReadback();
        logic [31:0] rd;
        wbRead(addrResult, rd);
        checkValue("reset result", 32'h0, rd);
        wbRead(addrStatus, rd);
        checkValue("reset status", 32'h0, rd);
        wbWrite(addrOpA, 32'h3F80_0000);
        wbWrite(addrOpB, 32'h4000_0000);
        wbWrite(addrCtrl, 32'h0000_0001);
        wbRead(addrOpA, rd);
        checkValue("readback OpA", 32'h3F80_0000, rd);
        wbRead(addrOpB, rd);
        checkValue("readback OpB", 32'h4000_0000, rd);
        wbRead(addrCtrl, rd);
        checkValue("readback Ctrl", 32'h0000_0001, rd);
        wbRead(addrResult, rd);
        checkValue("readback 1 - 2", 32'hBF80_0000, rd);
    endtask

    task automatic exactOps();
        runOp("1.5 + 2.25", 32'h3FC0_0000, 32'h4010_0000, 1'b0, 32'h4070_0000, 4'h0);
        runOp("3.0 - 1.0", 32'h4040_0000, 32'h3F80_0000, 1'b1, 32'h4000_0000, 4'h0);
        runOp("1.0 + 1.0", 32'h3F80_0000, 32'h3F80_0000, 1'b0, 32'h4000_0000, 4'h0);
        runOp("2.0 - 2.0", 32'h4000_0000, 32'h4000_0000, 1'b1, 32'h0000_0000, 4'h0);
        runOp("-5.0 + 3.0", 32'hC0A0_0000, 32'h4040_0000, 1'b0, 32'hC000_0000, 4'h0);
        runOp("1.0 - 0.75", 32'h3F80_0000, 32'h3F40_0000, 1'b1, 32'h3E80_0000, 4'h0);
    endtask

    task automatic roundingOps();
        runOp("tie to even down", 32'h3F80_0000, 32'h3380_0000, 1'b0, 32'h3F80_0000, flagInx);
        runOp("tie to even up", 32'h3F80_0001, 32'h3380_0000, 1'b0, 32'h3F80_0002, flagInx);
        runOp("sticky add", 32'h3F80_0000, 32'h3080_0000, 1'b0, 32'h3F80_0000, flagInx);
        runOp("sticky sub", 32'h3F80_0000, 32'h3080_0000, 1'b1, 32'h3F80_0000, flagInx);
        runOp("round carry", 32'h3FFF_FFFF, 32'h3380_0000, 1'b0, 32'h4000_0000, flagInx);
    endtask

    task automatic specialOps();
        runOp("NaN + 1", 32'h7FC0_0001, 32'h3F80_0000, 1'b0, quietNaN, flagInv);
        runOp("1 - NaN", 32'h3F80_0000, 32'hFF80_0001, 1'b1, quietNaN, flagInv);
        runOp("inf - inf", 32'h7F80_0000, 32'h7F80_0000, 1'b1, quietNaN, flagInv);
        runOp("inf + inf", 32'h7F80_0000, 32'h7F80_0000, 1'b0, 32'h7F80_0000, 4'h0);
        runOp("inf + 1", 32'h7F80_0000, 32'h3F80_0000, 1'b0, 32'h7F80_0000, 4'h0);
        runOp("1 - inf", 32'h3F80_0000, 32'h7F80_0000, 1'b1, 32'hFF80_0000, 4'h0);
        runOp("0 + x", 32'h0000_0000, 32'h4049_0FDB, 1'b0, 32'h4049_0FDB, 4'h0);
        runOp("0 - x", 32'h0000_0000, 32'h4049_0FDB, 1'b1, 32'hC049_0FDB, 4'h0);
        runOp("-0 + -0", 32'h8000_0000, 32'h8000_0000, 1'b0, 32'h8000_0000, 4'h0);
        runOp("+0 + -0", 32'h0000_0000, 32'h8000_0000, 1'b0, 32'h0000_0000, 4'h0);
        runOp("sub + normal", 32'h0040_0000, 32'h0080_0000, 1'b0, 32'h00C0_0000, 4'h0);
        runOp("sub + sub", 32'h0000_0001, 32'h0000_0001, 1'b0, 32'h0000_0000, flagUnf);
    endtask

    task automatic rangeOps();
        runOp("max + max", 32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, 32'h7F80_0000, flagOvf);
        runOp("-max - max", 32'hFF7F_FFFF, 32'h7F7F_FFFF, 1'b1, 32'hFF80_0000, flagOvf);
        runOp("tiny positive", 32'h0080_0001, 32'h0080_0000, 1'b1, 32'h0000_0000, flagUnf);
        runOp("tiny negative", 32'h8080_0001, 32'h8080_0000, 1'b1, 32'h8000_0000, flagUnf);
    endtask

    task automatic randomOps();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expRes;
        logic [3:0]  expStat;
        for (int i = 0; i < 200; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            // Every other pair gets close exponents so cancellation shows up
            if (i % 2 == 1)
                b[30:23] = a[30:23] ^ {5'b0, b[2:0]};
            for (int k = 0; k < 2; k++)
            begin
                expRes = fpAddModel(a, b, k[0], expStat);
                runOp($sformatf("random %h %s %h", a, k[0] ? "-" : "+", b),
                      a, b, k[0], expRes, expStat);
            end
        end
    endtask

    initial
    begin
        #(timeLimit);
        $display("Watchdog expired after %0d ns before the tests finished", timeLimit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        clk        = 1'b0;
        arstN      = 1'b0;
        wbCyc      = 1'b0;
        wbStb      = 1'b0;
        wbWe       = 1'b0;
        wbAdr      = '0;
        wbDatI     = '0;
        wbSel      = 4'hF;
        errCount   = 0;
        checkCount = 0;
        seed       = 32'h26a9;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        resetReadback();
        exactOps();
        roundingOps();
        specialOps();
        rangeOps();
        randomOps();
        errCount += i_dut.uChecker.assertFails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errCount, i_dut.uChecker.assertFails);
        if (errCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb/fpAddWb_checker.sv
// Bus and flag assertions
module fpAddWb_checker
    import fpPkg::*;
(
    input logic        clk,
    input logic        arstN,
    input logic        wbCyc,
    input logic        wbStb,
    input logic        wbAck,
    input logic [31:0] resultReg,
    input logic [31:0] statusReg
);
    timeunit 1ns;
    timeprecision 100ps;

    int assertFails = 0;

    ackAfterRequest: assert property (@(posedge clk) disable iff (!arstN)
        wbAck |-> $past(wbCyc && wbStb))
        else begin assertFails++; $error("wbAck without a preceding request"); end

    ackSingleCycle: assert property (@(posedge clk) disable iff (!arstN)
        wbAck |=> !wbAck)
        else begin assertFails++; $error("wbAck high for two cycles"); end

    ackLowInReset: assert property (@(posedge clk)
        !arstN |-> !wbAck)
        else begin assertFails++; $error("wbAck high during reset"); end

    // Invalid only ever comes with the canonical NaN
    invalidIsNaN: assert property (@(posedge clk) disable iff (!arstN)
        statusReg[statusInvalid] |-> (resultReg == quietNaN))
        else begin assertFails++; $error("invalid flag with a result other than quiet NaN"); end

endmodule

bind fpAddWb fpAddWb_checker uChecker
(
    .clk(clk),
    .arstN(arstN),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbAck(wbAck),
    .resultReg(resultReg),
    .statusReg(statusReg)
);
